/* bench/top_vga_assertions.sv */
`timescale 1ns/1ns

module top_vga_assertions #(
    parameter int H_SYNC = 96
) (
    input logic        clk,
    input logic        rst_n,
    input logic        hs,
    input logic        pready,
    input logic        hblnk,
    input logic        vblnk,
    input logic [11:0] rgb
);

    int hs_run;                                 // cycles hs has been high so far

    always_ff @(posedge clk) begin
        if (!rst_n)
            hs_run <= 0;
        else if (hs)
            hs_run <= hs_run + 1;
        else
            hs_run <= 0;
    end

    // ------------------------------------------------------------
    // properties
    // ------------------------------------------------------------
    hs_width: assert property (@(posedge clk) disable iff (!rst_n) $fell(hs) |-> hs_run == H_SYNC)
        else $error("hsync pulse width differs from H_SYNC");

    apb_ready: assert property (@(posedge clk) disable iff (!rst_n) pready)
        else $error("pready dropped");

    blank_black: assert property (@(posedge clk) disable iff (!rst_n) (hblnk || vblnk) |-> rgb == 12'h000)
        else $error("colour during blanking");

endmodule

bind top_vga top_vga_assertions #(.H_SYNC(H_SYNC)) u_top_vga_assertions (
    .clk(clk), .rst_n(rst_n), .hs(hs), .pready(apb_rsp.pready),
    .hblnk(bus_boss.hblnk), .vblnk(bus_boss.vblnk), .rgb(bus_boss.rgb)
);

/* bench/top_vga_tb.sv */
`timescale 1ns/1ns

module top_vga_tb;

    import vga_pkg::*;

    localparam int H_ACTIVE   = 40;
    localparam int H_FP       = 2;
    localparam int H_SYNC     = 4;
    localparam int H_BP       = 2;
    localparam int V_ACTIVE   = 20;
    localparam int V_FP       = 1;
    localparam int V_SYNC     = 2;
    localparam int V_BP       = 1;
    localparam int H_TOTAL    = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL    = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int FRAME      = H_TOTAL * V_TOTAL;
    localparam int LATENCY    = 3;
    localparam int NUM_FRAMES = 22;             // frames the test sequence needs at most
    localparam int MAX_FRAMES = 32;

    logic        clk = 1'b0;
    logic        rst_n;
    apb_req_t    apb_req;
    apb_rsp_t    apb_rsp;
    logic        hs;
    logic        vs;
    logic [3:0]  r;
    logic [3:0]  g;
    logic [3:0]  b;

    int          seed;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          edge_cnt;                      // clock edges since reset release
    sprite_cfg_t char_stg;
    sprite_cfg_t boss_stg;
    logic [11:0] bg_stg;
    sprite_cfg_t char_hist [MAX_FRAMES];        // live settings of each frame
    sprite_cfg_t boss_hist [MAX_FRAMES];
    logic [11:0] bg_hist   [MAX_FRAMES];

    top_vga #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_top_vga (
        .clk(clk), .rst_n(rst_n), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .hs(hs), .vs(vs), .r(r), .g(g), .b(b)
    );

    always #10 clk = ~clk;

    // ------------------------------------------------------------
    // pixel model
    // ------------------------------------------------------------
    function automatic logic in_rect(sprite_cfg_t cfg, int h, int v);
        return cfg.enable && h >= int'(cfg.x) && h < int'(cfg.x) + int'(cfg.w)
            && v >= int'(cfg.y) && v < int'(cfg.y) + int'(cfg.h);
    endfunction

    function automatic logic [11:0] model_rgb(int p);
        int          f;
        int          w;
        int          h;
        int          v;
        logic [11:0] col;
        f = p / FRAME;
        w = p % FRAME;
        h = w % H_TOTAL;
        v = w / H_TOTAL;
        if (h >= H_ACTIVE || v >= V_ACTIVE)
            return 12'h000;
        // bg stage sees the old colour at the origin
        col = (w == 0 && f > 0) ? bg_hist[f-1] : bg_hist[f];
        if (in_rect(char_hist[f], h, v))
            col = char_hist[f].color;
        if (in_rect(boss_hist[f], h, v))
            col = boss_hist[f].color;                           // boss on top
        return col;
    endfunction

    task automatic check_pixel();
        int          p;
        int          h;
        int          v;
        logic        exp_hs;
        logic        exp_vs;
        logic [11:0] exp_rgb;
        p       = edge_cnt - LATENCY;
        h       = (p < 0) ? 0 : (p % FRAME) % H_TOTAL;
        v       = (p < 0) ? 0 : (p % FRAME) / H_TOTAL;
        exp_hs  = (p >= 0) && h >= H_ACTIVE + H_FP && h < H_ACTIVE + H_FP + H_SYNC;
        exp_vs  = (p >= 0) && v >= V_ACTIVE + V_FP && v < V_ACTIVE + V_FP + V_SYNC;
        exp_rgb = (p < 0) ? 12'h000 : model_rgb(p);
        checks++;
        assert ({hs, vs, r, g, b} == {exp_hs, exp_vs, exp_rgb}) else begin
            errors++;
            $display("Mismatch at %0t: pixel (%0d,%0d) got hs=%b vs=%b rgb=%h, expected %b %b %h",
                     $time, h, v, hs, vs, {r, g, b}, exp_hs, exp_vs, exp_rgb);
        end
    endtask

    always @(posedge clk) begin
        #1;                                     // everything has settled after the edge
        if (rst_n) begin
            edge_cnt = edge_cnt + 1;
            if (edge_cnt % FRAME == 0 && edge_cnt / FRAME < MAX_FRAMES) begin
                char_hist[edge_cnt / FRAME] = char_stg;
                boss_hist[edge_cnt / FRAME] = boss_stg;
                bg_hist[edge_cnt / FRAME]   = bg_stg;
            end
            check_pixel();
        end
    end

    // ------------------------------------------------------------
    // APB
    // ------------------------------------------------------------
    task automatic model_write(input logic [4:0] addr, input logic [31:0] data);
        case (addr)
            REG_CHAR_POS:   {char_stg.y, char_stg.x} = data[23:0];
            REG_BOSS_POS:   {boss_stg.y, boss_stg.x} = data[23:0];
            REG_CHAR_STYLE: {char_stg.enable, char_stg.h, char_stg.w, char_stg.color} = data[28:0];
            REG_BOSS_STYLE: {boss_stg.enable, boss_stg.h, boss_stg.w, boss_stg.color} = data[28:0];
            REG_BG_COLOR:   bg_stg = data[11:0];
            default:        ;
        endcase
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data, input logic exp_err);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b1;
        apb_req.paddr   = addr;
        apb_req.pwdata  = data;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        assert (apb_rsp.pslverr == exp_err) else begin
            errors++;
            $display("Mismatch at %0t: write to %h gave pslverr=%b, expected %b",
                     $time, addr, apb_rsp.pslverr, exp_err);
        end
        @(posedge clk);
        if (!exp_err)
            model_write(addr, data);
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic err, output int at_edge);
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
        apb_req.paddr   = addr;
        @(negedge clk);
        apb_req.penable = 1'b1;
        #1;
        data    = apb_rsp.prdata;
        err     = apb_rsp.pslverr;
        at_edge = edge_cnt;
        @(negedge clk);
        apb_req = '0;
    endtask

    task automatic check_read(input logic [4:0] addr, input logic [31:0] exp);
        logic [31:0] data;
        logic        err;
        int          at_edge;
        apb_read(addr, data, err, at_edge);
        assert (data == exp && !err) else begin
            errors++;
            $display("Mismatch at %0t: read %h gave %h err=%b, expected %h",
                     $time, addr, data, err, exp);
        end
    endtask

    task automatic check_settings();
        check_read(REG_CHAR_POS, {8'h0, char_stg.y, char_stg.x});
        check_read(REG_BOSS_POS, {8'h0, boss_stg.y, boss_stg.x});
        check_read(REG_CHAR_STYLE,
                   {3'b0, char_stg.enable, char_stg.h, char_stg.w, char_stg.color});
        check_read(REG_BOSS_STYLE,
                   {3'b0, boss_stg.enable, boss_stg.h, boss_stg.w, boss_stg.color});
        check_read(REG_BG_COLOR, {20'h0, bg_stg});
    endtask

    // the counter steps one clock after each counted origin
    task automatic check_frame_count();
        logic [31:0] data;
        logic        err;
        int          at_edge;
        apb_read(REG_FRAME_CNT, data, err, at_edge);
        assert (data == 32'((at_edge - 1) / FRAME) && !err) else begin
            errors++;
            $display("Mismatch at %0t: frame count %0d err=%b, expected %0d",
                     $time, data, err, (at_edge - 1) / FRAME);
        end
    endtask

    // ------------------------------------------------------------
    // sequencing helpers
    // ------------------------------------------------------------
    task automatic wait_edge(input int target);
        while (edge_cnt < target)
            @(negedge clk);
    endtask

    // returns once every pixel of the frame after the next origin has been checked
    task automatic wait_next_frame_done();
        wait_edge((edge_cnt / FRAME + 2) * FRAME + LATENCY);
    endtask

    task automatic expect_pixel_at(input int frame, input int h, input int v,
                                   input logic [11:0] exp);
        wait_edge(frame * FRAME + v * H_TOTAL + h + LATENCY);
        assert ({r, g, b} == exp) else begin
            errors++;
            $display("Mismatch at %0t: pixel (%0d,%0d) is %h, expected %h",
                     $time, h, v, {r, g, b}, exp);
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors != err_before)
            tests_failed++;
        $display("test %-12s %s (%0d errors)", name, (errors == err_before) ? "ok" : "FAILED",
                 errors - err_before);
    endtask

    task automatic write_random_sprite(input logic [4:0] pos_addr, input logic [4:0] style_addr);
        logic [31:0] pos;
        logic [31:0] style;
        pos   = {8'h0, 12'($unsigned($random(seed)) % 26), 12'($unsigned($random(seed)) % 50)};
        style = {3'b0, ($unsigned($random(seed)) % 4) != 0,
                 8'($unsigned($random(seed)) % 16), 8'($unsigned($random(seed)) % 30),
                 12'($random(seed))};
        apb_write(pos_addr, pos, 1'b0);
        apb_write(style_addr, style, 1'b0);
    endtask

    // ------------------------------------------------------------
    // watchdog
    // ------------------------------------------------------------
    initial begin
        #((NUM_FRAMES * FRAME + 2000) * 20);
        $display("Timeout: the test sequence did not finish in %0d frames", NUM_FRAMES);
        $display(">>> FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------
    initial begin
        logic [31:0] data;
        logic        err;
        int          at_edge;
        int          e0;
        int          fc;
        logic [11:0] c1;
        logic [11:0] c2;
        seed         = 21131;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        edge_cnt     = 0;
        rst_n        = 1'b0;
        apb_req      = '0;
        char_stg     = '0;
        boss_stg     = '0;
        bg_stg       = 12'h248;
        char_hist[0] = '0;
        boss_hist[0] = '0;
        bg_hist[0]   = 12'h248;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;                            // reset frame, sprites off
        wait_edge(FRAME + LATENCY);
        end_test("sync_bg", e0);

        e0 = errors;
        apb_write(REG_BG_COLOR, {20'h0, 12'($random(seed))}, 1'b0);
        wait_next_frame_done();
        end_test("bg_write", e0);

        e0 = errors;
        repeat (4) begin
            write_random_sprite(REG_CHAR_POS, REG_CHAR_STYLE);
            write_random_sprite(REG_BOSS_POS, REG_BOSS_STYLE);
            wait_next_frame_done();
        end
        end_test("random", e0);

        e0 = errors;
        apb_write(REG_CHAR_POS, {8'h0, 12'd5, 12'd5}, 1'b0);
        apb_write(REG_CHAR_STYLE, {3'b0, 1'b1, 8'd10, 8'd20, 12'h0f0}, 1'b0);
        apb_write(REG_BOSS_POS, {8'h0, 12'd8, 12'd10}, 1'b0);
        apb_write(REG_BOSS_STYLE, {3'b0, 1'b1, 8'd10, 8'd15, 12'hf00}, 1'b0);
        wait_next_frame_done();
        expect_pixel_at(edge_cnt / FRAME, 12, 10, 12'hf00);
        end_test("overlap", e0);

        e0 = errors;
        c1 = 12'($random(seed)) | 12'h001;
        c2 = ~c1;
        apb_write(REG_CHAR_STYLE, 32'h0, 1'b0);
        apb_write(REG_BOSS_STYLE, 32'h0, 1'b0);
        apb_write(REG_BG_COLOR, {20'h0, c1}, 1'b0);
        wait_next_frame_done();
        fc = edge_cnt / FRAME;
        wait_edge(fc * FRAME + 500);            // middle of the frame
        apb_write(REG_BG_COLOR, {20'h0, c2}, 1'b0);
        expect_pixel_at(fc, 30, 18, c1);
        expect_pixel_at(fc + 1, 30, 18, c2);
        end_test("shadow", e0);

        e0 = errors;
        check_settings();
        check_frame_count();
        apb_write(REG_FRAME_CNT, 32'h0, 1'b1);
        apb_write(5'h18, 32'hffff_ffff, 1'b1);
        apb_write(5'h02, 32'hffff_ffff, 1'b1);
        apb_read(5'h1c, data, err, at_edge);
        assert (err) else begin
            errors++;
            $display("Mismatch at %0t: read of unmapped %h gave pslverr=%b, expected 1",
                     $time, 5'h1c, err);
        end
        check_settings();
        check_frame_count();
        end_test("registers", e0);

        $display("tests %0d, failed %0d, pixel checks %0d, errors %0d",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0 && tests_failed == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

/* project.f */
src/vga_pkg.sv
src/vga_timing.sv
src/draw_bg.sv
src/draw_rect.sv
src/game_regs.sv
src/top_vga.sv
bench/top_vga_assertions.sv
bench/top_vga_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the VGA testbench with Verilator
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module top_vga_tb \
    -f project.f -o sim \
    && ./obj_dir/sim 2>&1 | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "simulation did not complete"; exit 1; }
echo "simulation passed"
exit 0

/* src/draw_bg.sv */
`timescale 1ns/1ns

module draw_bg (
    input  logic              clk,
    input  logic              rst_n,
    input  vga_pkg::vga_bus_t bus_in,
    input  logic [11:0]       bg_color,
    output vga_pkg::vga_bus_t bus_out
);

    logic        blank;
    logic [11:0] rgb_nxt;

    assign blank   = bus_in.hblnk || bus_in.vblnk;
    assign rgb_nxt = blank ? 12'h000 : bg_color;    // black outside the visible area

    // ----------------------------------------------------------
    // pipeline register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_out <= '0;
        end else begin
            bus_out.hcount <= bus_in.hcount;
            bus_out.vcount <= bus_in.vcount;
            bus_out.hsync  <= bus_in.hsync;
            bus_out.vsync  <= bus_in.vsync;
            bus_out.hblnk  <= bus_in.hblnk;
            bus_out.vblnk  <= bus_in.vblnk;
            bus_out.rgb    <= rgb_nxt;
        end
    end

endmodule

/* src/draw_rect.sv */
`timescale 1ns/1ns

module draw_rect (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vga_pkg::vga_bus_t    bus_in,
    input  vga_pkg::sprite_cfg_t cfg,
    output vga_pkg::vga_bus_t    bus_out
);

    logic [12:0] x_end;
    logic [12:0] y_end;
    logic [12:0] hpos;
    logic [12:0] vpos;
    logic        in_x;
    logic        in_y;
    logic        visible;
    logic        hit;
    logic [11:0] rgb_nxt;

    // ----------------------------------------------------------
    // rectangle test
    // ----------------------------------------------------------
    // one extra bit so x + w never wraps near the right edge
    assign x_end = {1'b0, cfg.x} + {5'b0, cfg.w};
    assign y_end = {1'b0, cfg.y} + {5'b0, cfg.h};
    assign hpos  = {2'b0, bus_in.hcount};
    assign vpos  = {2'b0, bus_in.vcount};

    assign in_x    = (hpos >= {1'b0, cfg.x}) && (hpos < x_end);   // half open, x to x+w
    assign in_y    = (vpos >= {1'b0, cfg.y}) && (vpos < y_end);
    assign visible = !bus_in.hblnk && !bus_in.vblnk;
    assign hit     = cfg.enable && visible && in_x && in_y;

    assign rgb_nxt = hit ? cfg.color : bus_in.rgb;    // pixels beneath show through

    // ----------------------------------------------------------
    // pipeline register
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            bus_out <= '0;
        end else begin
            bus_out.hcount <= bus_in.hcount;
            bus_out.vcount <= bus_in.vcount;
            bus_out.hsync  <= bus_in.hsync;
            bus_out.vsync  <= bus_in.vsync;
            bus_out.hblnk  <= bus_in.hblnk;
            bus_out.vblnk  <= bus_in.vblnk;
            bus_out.rgb    <= rgb_nxt;
        end
    end

endmodule

/* src/game_regs.sv */
`timescale 1ns/1ns

module game_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  vga_pkg::apb_req_t    apb_req,
    input  logic                 frame_start,
    output vga_pkg::apb_rsp_t    apb_rsp,
    output vga_pkg::sprite_cfg_t char_cfg,
    output vga_pkg::sprite_cfg_t boss_cfg,
    output logic [11:0]          bg_color
);

    import vga_pkg::*;

    sprite_cfg_t char_stg;
    sprite_cfg_t boss_stg;
    logic [11:0] bg_stg;
    logic [31:0] frame_cnt;
    reg_word_u   wword;
    reg_word_u   rword;
    logic        access;
    logic        addr_ok;
    logic        bad;
    logic        wr_en;

    // ----------------------------------------------------------
    // word layouts
    // ----------------------------------------------------------
    function automatic sprite_cfg_t with_pos(sprite_cfg_t cfg, reg_word_u word);
        sprite_cfg_t upd;
        upd   = cfg;
        upd.x = word.pos.x;
        upd.y = word.pos.y;
        return upd;
    endfunction

    function automatic sprite_cfg_t with_style(sprite_cfg_t cfg, reg_word_u word);
        sprite_cfg_t upd;
        upd        = cfg;
        upd.color  = word.style.color;
        upd.w      = word.style.w;
        upd.h      = word.style.h;
        upd.enable = word.style.enable;
        return upd;
    endfunction

    function automatic reg_word_u pos_word(sprite_cfg_t cfg);
        reg_word_u word;
        word       = '0;                        // reserved bits read back as zero
        word.pos.x = cfg.x;
        word.pos.y = cfg.y;
        return word;
    endfunction

    function automatic reg_word_u style_word(sprite_cfg_t cfg);
        reg_word_u word;
        word              = '0;
        word.style.color  = cfg.color;
        word.style.w      = cfg.w;
        word.style.h      = cfg.h;
        word.style.enable = cfg.enable;
        return word;
    endfunction

    // ----------------------------------------------------------
    // APB decode, zero wait states
    // ----------------------------------------------------------
    assign wword  = apb_req.pwdata;
    assign access = apb_req.psel && apb_req.penable;

    always_comb begin
        case (apb_req.paddr)
            REG_CHAR_POS, REG_CHAR_STYLE, REG_BOSS_POS,
            REG_BOSS_STYLE, REG_BG_COLOR, REG_FRAME_CNT: addr_ok = 1'b1;
            default:                                      addr_ok = 1'b0;
        endcase
    end

    assign bad   = access && (!addr_ok || (apb_req.pwrite && apb_req.paddr == REG_FRAME_CNT));
    assign wr_en = access && apb_req.pwrite && !bad;

    always_comb begin
        case (apb_req.paddr)
            REG_CHAR_POS:   rword = pos_word(char_stg);
            REG_CHAR_STYLE: rword = style_word(char_stg);
            REG_BOSS_POS:   rword = pos_word(boss_stg);
            REG_BOSS_STYLE: rword = style_word(boss_stg);
            REG_BG_COLOR:   rword = {20'h0, bg_stg};
            REG_FRAME_CNT:  rword = frame_cnt;
            default:        rword = '0;
        endcase
    end

    assign apb_rsp = '{prdata: rword, pready: 1'b1, pslverr: bad};

    // ----------------------------------------------------------
    // staging and live copies
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            char_stg <= SPRITE_CFG_RST;
            boss_stg <= SPRITE_CFG_RST;
            bg_stg   <= BG_COLOR_RST;
        end else if (wr_en) begin
            case (apb_req.paddr)
                REG_CHAR_POS:   char_stg <= with_pos(char_stg, wword);
                REG_CHAR_STYLE: char_stg <= with_style(char_stg, wword);
                REG_BOSS_POS:   boss_stg <= with_pos(boss_stg, wword);
                REG_BOSS_STYLE: boss_stg <= with_style(boss_stg, wword);
                REG_BG_COLOR:   bg_stg   <= apb_req.pwdata[11:0];
                default:        ;
            endcase
        end
    end

    // the pixel path only sees new settings from the frame origin on
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            char_cfg  <= SPRITE_CFG_RST;
            boss_cfg  <= SPRITE_CFG_RST;
            bg_color  <= BG_COLOR_RST;
            frame_cnt <= '0;
        end else if (frame_start) begin
            char_cfg  <= char_stg;
            boss_cfg  <= boss_stg;
            bg_color  <= bg_stg;
            frame_cnt <= frame_cnt + 32'd1;
        end
    end

endmodule

/* src/top_vga.sv */
`timescale 1ns/1ns

module top_vga #(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 33
) (
    input  logic              clk,
    input  logic              rst_n,
    input  vga_pkg::apb_req_t apb_req,
    output vga_pkg::apb_rsp_t apb_rsp,
    output logic              hs,
    output logic              vs,
    output logic [3:0]        r,
    output logic [3:0]        g,
    output logic [3:0]        b
);

    import vga_pkg::*;

    vga_bus_t    bus_tim;
    vga_bus_t    bus_bg;
    vga_bus_t    bus_char;
    vga_bus_t    bus_boss;
    sprite_cfg_t char_cfg;
    sprite_cfg_t boss_cfg;
    logic [11:0] bg_color;
    logic        frame_start;

    // ----------------------------------------------------------
    // pixel pipeline, boss drawn last so it sits on top
    // ----------------------------------------------------------
    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_ACTIVE(V_ACTIVE), .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) u_vga_timing (
        .clk        (clk),
        .rst_n      (rst_n),
        .timing     (bus_tim),
        .frame_start(frame_start)
    );

    draw_bg u_draw_bg (
        .clk     (clk),
        .rst_n   (rst_n),
        .bus_in  (bus_tim),
        .bg_color(bg_color),
        .bus_out (bus_bg)
    );

    draw_rect u_draw_char (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus_in (bus_bg),
        .cfg    (char_cfg),
        .bus_out(bus_char)
    );

    draw_rect u_draw_boss (
        .clk    (clk),
        .rst_n  (rst_n),
        .bus_in (bus_char),
        .cfg    (boss_cfg),
        .bus_out(bus_boss)
    );

    game_regs u_game_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .apb_req    (apb_req),
        .frame_start(frame_start),
        .apb_rsp    (apb_rsp),
        .char_cfg   (char_cfg),
        .boss_cfg   (boss_cfg),
        .bg_color   (bg_color)
    );

    assign hs        = bus_boss.hsync;
    assign vs        = bus_boss.vsync;
    assign {r, g, b} = bus_boss.rgb;

endmodule

/* src/vga_pkg.sv */
package vga_pkg;

    // ----------------------------------------------------------
    // pixel bus and sprite settings
    // ----------------------------------------------------------
    typedef struct packed {
        logic [10:0] hcount;
        logic [10:0] vcount;
        logic        hsync;
        logic        vsync;
        logic        hblnk;
        logic        vblnk;
        logic [11:0] rgb;                       // 4:4:4 with red in the top nibble
    } vga_bus_t;

    typedef struct packed {
        logic [11:0] x;                         // top left corner
        logic [11:0] y;
        logic [7:0]  w;
        logic [7:0]  h;
        logic [11:0] color;
        logic        enable;
    } sprite_cfg_t;

    // ----------------------------------------------------------
    // APB
    // ----------------------------------------------------------
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [4:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

    // one register word, seen as a position or as a style depending on the offset
    typedef union packed {
        struct packed {
            logic [7:0]  rsvd;
            logic [11:0] y;
            logic [11:0] x;
        } pos;
        struct packed {
            logic [2:0]  rsvd;
            logic        enable;
            logic [7:0]  h;
            logic [7:0]  w;
            logic [11:0] color;
        } style;
    } reg_word_u;

    localparam logic [4:0] REG_CHAR_POS   = 5'h00;
    localparam logic [4:0] REG_CHAR_STYLE = 5'h04;
    localparam logic [4:0] REG_BOSS_POS   = 5'h08;
    localparam logic [4:0] REG_BOSS_STYLE = 5'h0C;
    localparam logic [4:0] REG_BG_COLOR   = 5'h10;
    localparam logic [4:0] REG_FRAME_CNT  = 5'h14;  // read only

    localparam logic [11:0] BG_COLOR_RST   = 12'h248;
    localparam sprite_cfg_t SPRITE_CFG_RST = '0;    // disabled, at the origin, no size

endpackage

/* src/vga_timing.sv */
`timescale 1ns/1ns

module vga_timing #(
    parameter int H_ACTIVE = 640,
    parameter int H_FP     = 16,
    parameter int H_SYNC   = 96,
    parameter int H_BP     = 48,
    parameter int V_ACTIVE = 480,
    parameter int V_FP     = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BP     = 33
) (
    input  logic              clk,
    input  logic              rst_n,
    output vga_pkg::vga_bus_t timing,
    output logic              frame_start
);

    localparam int H_TOTAL = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL = V_ACTIVE + V_FP + V_SYNC + V_BP;

    localparam logic [10:0] H_LAST       = 11'(H_TOTAL - 1);
    localparam logic [10:0] H_BLNK_START = 11'(H_ACTIVE);
    localparam logic [10:0] H_SYNC_START = 11'(H_ACTIVE + H_FP);
    localparam logic [10:0] H_SYNC_END   = 11'(H_ACTIVE + H_FP + H_SYNC);

    localparam logic [10:0] V_LAST       = 11'(V_TOTAL - 1);
    localparam logic [10:0] V_BLNK_START = 11'(V_ACTIVE);
    localparam logic [10:0] V_SYNC_START = 11'(V_ACTIVE + V_FP);
    localparam logic [10:0] V_SYNC_END   = 11'(V_ACTIVE + V_FP + V_SYNC);

    logic [10:0] h_next;
    logic [10:0] v_next;

    // ----------------------------------------------------------
    // counter stepping
    // ----------------------------------------------------------
    always_comb begin
        h_next = timing.hcount + 11'd1;
        v_next = timing.vcount;
        if (timing.hcount == H_LAST) begin
            h_next = '0;
            v_next = (timing.vcount == V_LAST) ? 11'd0 : timing.vcount + 11'd1;
        end
    end

    // ----------------------------------------------------------
    // registered outputs
    // ----------------------------------------------------------
    // flags are decoded from the next count so they line up with the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            timing      <= '0;
            frame_start <= 1'b0;
        end else begin
            timing.hcount <= h_next;
            timing.vcount <= v_next;
            timing.hsync  <= (h_next >= H_SYNC_START) && (h_next < H_SYNC_END);
            timing.vsync  <= (v_next >= V_SYNC_START) && (v_next < V_SYNC_END);
            timing.hblnk  <= (h_next >= H_BLNK_START);
            timing.vblnk  <= (v_next >= V_BLNK_START);
            timing.rgb    <= '0;                // the stages paint from here on
            frame_start   <= (h_next == 11'd0) && (v_next == 11'd0);
        end
    end

endmodule
